// File: hdl/rt_pkg.sv
`default_nettype none

package rt_pkg;

  // Frame geometry in pixels
  localparam int FRAME_W = 16;
  localparam int FRAME_H = 12;

  // Scene size limit and index width (also holds the count 0..MAX_OBJS)
  localparam int MAX_OBJS  = 8;
  localparam int OBJ_IDX_W = 4;

  // Squared distance >> SHADE_SHIFT is subtracted from full brightness
  localparam int SHADE_SHIFT = 2;

  // Colour of pixels that hit nothing, RGB 8:8:8
  localparam logic [23:0] BG_COLOR = 24'h203050;

  // World position of pixel (0,0)
  typedef struct packed {
    logic signed [11:0] x;
    logic signed [11:0] y;
  } camera_t;

  // One scene object as delivered by the scene buffer
  typedef struct packed {
    logic signed [11:0] cx;
    logic signed [11:0] cy;
    // Depth of the centre, smaller is nearer
    logic [11:0]        cz;
    logic [7:0]         r;
    // Red in the top byte, blue in the bottom byte
    logic [23:0]        color;
  } sphere_t;

  // One finished pixel with its frame coordinates
  typedef struct packed {
    logic [3:0]  h;
    logic [3:0]  v;
    // RGB565, red in bits 15:11
    logic [15:0] rgb;
  } pixel_t;

endpackage

`default_nettype wire

// File: hdl/pixel_scan.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_scan import rt_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       clear,
  input  logic       step,
  output logic [3:0] h,
  output logic [3:0] v,
  output logic       last_pix
);

  logic end_of_line;
  logic end_of_frame;

  // Column and row limits of the frame
  assign end_of_line  = (h == 4'(FRAME_W - 1));
  assign end_of_frame = (v == 4'(FRAME_H - 1));

  // Final pixel of the raster, bottom right
  assign last_pix = end_of_line && end_of_frame;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h <= '0;
      v <= '0;
    end else if (clear) begin
      // Back to the top left corner for a new frame
      h <= '0;
      v <= '0;
    end else if (step) begin
      if (end_of_line) begin
        h <= '0;
        // Next line, wrapping to the top after the last one
        if (end_of_frame) begin
          v <= '0;
        end else begin
          v <= v + 4'd1;
        end
      end else begin
        h <= h + 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/sphere_hit.sv
`timescale 1ns/1ps
`default_nettype none

module sphere_hit import rt_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               test,
  input  logic signed [11:0] ray_x,
  input  logic signed [11:0] ray_y,
  input  sphere_t            obj,
  output logic               done,
  output logic               hit,
  output logic [7:0]         shade
);

  // Offsets from the centre wide enough that the squares never wrap
  logic signed [25:0] dx;
  logic signed [25:0] dy;
  logic [25:0]        dist2;
  logic [15:0]        r2;
  logic [25:0]        loss;
  logic               hit_c;
  logic [7:0]         shade_c;

  // Ray runs along z, so only x and y matter for the distance
  assign dx = 26'(ray_x) - 26'($signed(obj.cx));
  assign dy = 26'(ray_y) - 26'($signed(obj.cy));

  // Squared distance from the ray to the centre
  assign dist2 = dx * dx + dy * dy;

  // Radius squared fits in 16 bits
  assign r2 = 16'(obj.r) * 16'(obj.r);

  // Inside or on the silhouette counts as a hit
  assign hit_c = (dist2 <= {10'd0, r2});

  // Brightness falls off with distance from the centre line
  assign loss = dist2 >> SHADE_SHIFT;

  always_comb begin
    // Saturate at zero once the loss reaches full brightness
    if (loss > 26'd255) begin
      shade_c = 8'd0;
    end else begin
      shade_c = 8'd255 - loss[7:0];
    end
  end

  // Strobe one cycle behind test
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= test;
    end
  end

  // Results captured with the strobe and held until the next test
  always_ff @(posedge clk) begin
    if (test) begin
      hit   <= hit_c;
      shade <= shade_c;
    end
  end

endmodule

`default_nettype wire

// File: hdl/color_565.sv
`timescale 1ns/1ps
`default_nettype none

module color_565 import rt_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        go,
  input  logic        found,
  input  logic [23:0] color,
  input  logic [7:0]  shade,
  output logic        valid,
  output logic [15:0] rgb
);

  // 16 bit products of channel and shade
  logic [15:0] prod_r;
  logic [15:0] prod_g;
  logic [15:0] prod_b;
  // Final 8 bit channels before truncation
  logic [23:0] lit;

  assign prod_r = 16'(color[23:16]) * 16'(shade);
  assign prod_g = 16'(color[15:8]) * 16'(shade);
  assign prod_b = 16'(color[7:0]) * 16'(shade);

  // Upper byte of each product or the plain background on a miss
  assign lit = found ? {prod_r[15:8], prod_g[15:8], prod_b[15:8]} : BG_COLOR;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else begin
      valid <= go;
    end
  end

  // Keep the top 5, 6 and 5 bits of red, green and blue
  always_ff @(posedge clk) begin
    if (go) begin
      rgb <= {lit[23:19], lit[15:10], lit[7:3]};
    end
  end

endmodule

`default_nettype wire

// File: hdl/trace_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module trace_fsm import rt_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  camera_t              cam,
  input  logic [OBJ_IDX_W-1:0] num_objs,
  output logic                 obj_req,
  output logic [OBJ_IDX_W-1:0] obj_idx,
  input  logic                 obj_ack,
  input  sphere_t              obj,
  output logic                 pix_req,
  output pixel_t               pix,
  input  logic                 pix_ack,
  output logic                 busy,
  output logic                 scan_clear,
  output logic                 scan_step,
  input  logic [3:0]           h,
  input  logic [3:0]           v,
  input  logic                 last_pix,
  output logic                 hit_test,
  output sphere_t              hit_obj,
  output logic signed [11:0]   ray_x,
  output logic signed [11:0]   ray_y,
  input  logic                 hit_done,
  input  logic                 hit,
  input  logic [7:0]           shade,
  output logic                 col_go,
  output logic                 found,
  output logic [23:0]          best_color,
  output logic [7:0]           best_shade,
  input  logic                 col_valid,
  input  logic [15:0]          rgb
);

  typedef enum logic [2:0] {IDLE, FETCH, RELEASE, TEST, COLOR, OUT, DRAIN} state_t;

  state_t               state;
  logic [OBJ_IDX_W-1:0] obj_cnt;
  logic [OBJ_IDX_W-1:0] obj_next;
  logic                 empty_scene;
  logic                 new_best;
  // Depth of the current best candidate
  logic [11:0]          best_cz;

  // Scene size clipped to what the buffer can hold
  assign obj_cnt     = (num_objs > OBJ_IDX_W'(MAX_OBJS)) ? OBJ_IDX_W'(MAX_OBJS) : num_objs;
  assign obj_next    = obj_idx + OBJ_IDX_W'(1);
  assign empty_scene = (obj_cnt == '0);

  // Only a strictly nearer hit replaces the best so a tie keeps the earlier index
  assign new_best = hit && (!found || (hit_obj.cz < best_cz));

  // Orthographic ray at camera offset plus pixel position
  assign ray_x = cam.x + $signed({8'd0, h});
  assign ray_y = cam.y + $signed({8'd0, v});

  // Handshake requests follow the state directly
  assign obj_req = (state == FETCH);
  assign pix_req = (state == OUT);

  assign scan_clear = (state == IDLE) && start;
  // Advance once the sink has released ack unless this was the final pixel
  assign scan_step  = (state == DRAIN) && !pix_ack && !last_pix;

  // Test fires as the scene buffer drops ack
  assign hit_test = (state == RELEASE) && !obj_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      busy    <= 1'b0;
      obj_idx <= '0;
      found   <= 1'b0;
      col_go  <= 1'b0;
    end else begin
      col_go <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            busy    <= 1'b1;
            obj_idx <= '0;
            found   <= 1'b0;
            // No objects means straight to background
            if (empty_scene) begin
              state  <= COLOR;
              col_go <= 1'b1;
            end else begin
              state <= FETCH;
            end
          end
        end
        FETCH: begin
          if (obj_ack) state <= RELEASE;
        end
        RELEASE: begin
          if (!obj_ack) state <= TEST;
        end
        TEST: begin
          if (hit_done) begin
            if (new_best) found <= 1'b1;
            // Shade the winner after the last object
            if (obj_next == obj_cnt) begin
              state  <= COLOR;
              col_go <= 1'b1;
            end else begin
              obj_idx <= obj_next;
              state   <= FETCH;
            end
          end
        end
        COLOR: begin
          if (col_valid) state <= OUT;
        end
        OUT: begin
          if (pix_ack) state <= DRAIN;
        end
        DRAIN: begin
          if (!pix_ack) begin
            if (last_pix) begin
              state <= IDLE;
              busy  <= 1'b0;
            end else begin
              // Next pixel starts from the first object
              obj_idx <= '0;
              found   <= 1'b0;
              if (empty_scene) begin
                state  <= COLOR;
                col_go <= 1'b1;
              end else begin
                state <= FETCH;
              end
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    // Sphere sampled while ack is high
    if ((state == FETCH) && obj_ack) begin
      hit_obj <= obj;
    end
    // Keep the nearest hit so far
    if ((state == TEST) && hit_done && new_best) begin
      best_cz    <= hit_obj.cz;
      best_color <= hit_obj.color;
      best_shade <= shade;
    end
    // Pixel held from req rise through ack fall
    if ((state == COLOR) && col_valid) begin
      pix.h   <= h;
      pix.v   <= v;
      pix.rgb <= rgb;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rtx_core.sv
`timescale 1ns/1ps
`default_nettype none

module rtx_core import rt_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  camera_t              cam,
  input  logic [OBJ_IDX_W-1:0] num_objs,
  // Scene fetch
  output logic                 obj_req,
  output logic [OBJ_IDX_W-1:0] obj_idx,
  input  logic                 obj_ack,
  input  sphere_t              obj,
  // Pixel output
  output logic                 pix_req,
  output pixel_t               pix,
  input  logic                 pix_ack,
  output logic                 busy
);

  // Raster position
  logic              scan_clear;
  logic              scan_step;
  logic [3:0]        h;
  logic [3:0]        v;
  logic              last_pix;

  // Hit test path
  logic              hit_test;
  sphere_t           hit_obj;
  logic signed [11:0] ray_x;
  logic signed [11:0] ray_y;
  logic              hit_done;
  logic              hit;
  logic [7:0]        shade;

  // Colour path
  logic              col_go;
  logic              found;
  logic [23:0]       best_color;
  logic [7:0]        best_shade;
  logic              col_valid;
  logic [15:0]       rgb;

  pixel_scan pixel_scan_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear    (scan_clear),
    .step     (scan_step),
    .h        (h),
    .v        (v),
    .last_pix (last_pix)
  );

  trace_fsm trace_fsm_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .cam        (cam),
    .num_objs   (num_objs),
    .obj_req    (obj_req),
    .obj_idx    (obj_idx),
    .obj_ack    (obj_ack),
    .obj        (obj),
    .pix_req    (pix_req),
    .pix        (pix),
    .pix_ack    (pix_ack),
    .busy       (busy),
    .scan_clear (scan_clear),
    .scan_step  (scan_step),
    .h          (h),
    .v          (v),
    .last_pix   (last_pix),
    .hit_test   (hit_test),
    .hit_obj    (hit_obj),
    .ray_x      (ray_x),
    .ray_y      (ray_y),
    .hit_done   (hit_done),
    .hit        (hit),
    .shade      (shade),
    .col_go     (col_go),
    .found      (found),
    .best_color (best_color),
    .best_shade (best_shade),
    .col_valid  (col_valid),
    .rgb        (rgb)
  );

  sphere_hit sphere_hit_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .test  (hit_test),
    .ray_x (ray_x),
    .ray_y (ray_y),
    .obj   (hit_obj),
    .done  (hit_done),
    .hit   (hit),
    .shade (shade)
  );

  // Shading multiply and 565 packing of the winner
  color_565 color_565_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .go    (col_go),
    .found (found),
    .color (best_color),
    .shade (best_shade),
    .valid (col_valid),
    .rgb   (rgb)
  );

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 100 ns period, first rising edge at 50 ns
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset low for 8 rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/rtx_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rtx_checker import rt_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic                 busy,
  input  logic                 pix_req,
  input  logic                 pix_ack,
  input  pixel_t               pix,
  input  camera_t              cam,
  input  logic [OBJ_IDX_W-1:0] num_objs,
  input  sphere_t              scene [MAX_OBJS],
  output int                   err_cnt,
  output int                   pix_cnt
);

  logic       ack_q;
  // Next raster position the DUT should deliver
  logic [3:0] exp_h;
  logic [3:0] exp_v;
  int         cmp_errs;
  int         hold_errs;
  // Handshake in progress during the previous cycle
  logic       hold_q;
  pixel_t     pix_q;

  assign err_cnt = cmp_errs + hold_errs;

  // Reference pixel colour at frame position (px, py)
  function automatic logic [15:0] model_rgb(input int px, input int py);
    int          rx;
    int          ry;
    int          dx;
    int          dy;
    int          d2;
    int          loss;
    int          shade;
    int          best_cz;
    int          i;
    logic        found;
    logic [23:0] c;
    logic [7:0]  ch_r;
    logic [7:0]  ch_g;
    logic [7:0]  ch_b;
    found   = 1'b0;
    best_cz = 0;
    shade   = 0;
    c       = BG_COLOR;
    // Orthographic ray through the pixel
    rx = int'(cam.x) + px;
    ry = int'(cam.y) + py;
    for (i = 0; i < int'(num_objs) && i < MAX_OBJS; i++) begin
      dx = rx - int'(scene[i].cx);
      dy = ry - int'(scene[i].cy);
      d2 = dx * dx + dy * dy;
      // Hit when within the radius
      if (d2 <= int'(scene[i].r) * int'(scene[i].r)) begin
        // Index order scan keeps the first of equal depths
        if (!found || int'(scene[i].cz) < best_cz) begin
          found   = 1'b1;
          best_cz = int'(scene[i].cz);
          c       = scene[i].color;
          loss    = d2 >>> SHADE_SHIFT;
          shade   = (loss > 255) ? 0 : 255 - loss;
        end
      end
    end
    if (found) begin
      ch_r = 8'((int'(c[23:16]) * shade) >>> 8);
      ch_g = 8'((int'(c[15:8]) * shade) >>> 8);
      ch_b = 8'((int'(c[7:0]) * shade) >>> 8);
    end else begin
      // Background goes out unshaded
      ch_r = BG_COLOR[23:16];
      ch_g = BG_COLOR[15:8];
      ch_b = BG_COLOR[7:0];
    end
    return {ch_r[7:3], ch_g[7:2], ch_b[7:3]};
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q    <= 1'b0;
      exp_h    <= '0;
      exp_v    <= '0;
      cmp_errs <= 0;
      pix_cnt  <= 0;
    end else begin
      ack_q <= pix_ack;
      if (start && !busy) begin
        // Raster begins again at the corner on an accepted start
        exp_h <= '0;
        exp_v <= '0;
      end else if (pix_ack && !ack_q) begin
        // Pixel taken on the rising edge of ack
        pix_cnt <= pix_cnt + 1;
        if (pix.h != exp_h || pix.v != exp_v) begin
          $display("Error at %0t: pixel at (%0d,%0d), expected (%0d,%0d)",
                   $time, pix.h, pix.v, exp_h, exp_v);
          cmp_errs <= cmp_errs + 1;
        end else if (pix.rgb != model_rgb(int'(exp_h), int'(exp_v))) begin
          $display("Error at %0t: pixel (%0d,%0d) rgb %h, expected %h",
                   $time, pix.h, pix.v, pix.rgb, model_rgb(int'(exp_h), int'(exp_v)));
          cmp_errs <= cmp_errs + 1;
        end
        // Raster order with h fastest
        if (exp_h == 4'(FRAME_W - 1)) begin
          exp_h <= '0;
          exp_v <= (exp_v == 4'(FRAME_H - 1)) ? 4'd0 : exp_v + 4'd1;
        end else begin
          exp_h <= exp_h + 4'd1;
        end
      end
    end
  end

  // Pixel must stay put from the rise of req to the fall of ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_q    <= 1'b0;
      pix_q     <= '0;
      hold_errs <= 0;
    end else begin
      hold_q <= pix_req || pix_ack;
      pix_q  <= pix;
      if (hold_q && (pix_req || pix_ack) && pix != pix_q) begin
        $display("Error at %0t: pixel changed from %h to %h during its handshake",
                 $time, pix_q, pix);
        hold_errs <= hold_errs + 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/rtx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rtx_tb import rt_pkg::*; #(
  parameter logic [31:0] SEED = 32'h0453_63ff
);

  logic                 clk;
  logic                 rst_n;
  logic                 start;
  camera_t              cam;
  logic [OBJ_IDX_W-1:0] num_objs;
  logic                 obj_req;
  logic [OBJ_IDX_W-1:0] obj_idx;
  logic                 obj_ack;
  sphere_t              obj;
  logic                 pix_req;
  pixel_t               pix;
  logic                 pix_ack;
  logic                 busy;

  // Scene buffer contents, also seen by the checker
  sphere_t     scene [MAX_OBJS];
  // Random handshake delays when set
  logic        slow;
  // Separate LFSR states for stimulus and for the responders
  logic [31:0] lfsr_state;
  logic [31:0] dly_state;
  int          obj_dly;
  int          pix_dly;
  int          fetch_cnt;
  int          chk_errs;
  int          pix_cnt;
  int          tb_errs;
  int          tests;
  int          failed_tests;
  logic        aborted;

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit collected
  function automatic logic [31:0] take_bits(input int n, inout logic [31:0] state);
    logic [31:0] val;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val   = {val[30:0], state[0]};
      state = lfsr_step(state);
    end
    return val;
  endfunction

  function automatic logic [31:0] draw(input int n);
    return take_bits(n, lfsr_state);
  endfunction

  function automatic int error_total();
    return chk_errs + tb_errs;
  endfunction

  tb_clock tb_clock_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rtx_core rtx_core_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .cam      (cam),
    .num_objs (num_objs),
    .obj_req  (obj_req),
    .obj_idx  (obj_idx),
    .obj_ack  (obj_ack),
    .obj      (obj),
    .pix_req  (pix_req),
    .pix      (pix),
    .pix_ack  (pix_ack),
    .busy     (busy)
  );

  rtx_checker rtx_checker_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .busy     (busy),
    .pix_req  (pix_req),
    .pix_ack  (pix_ack),
    .pix      (pix),
    .cam      (cam),
    .num_objs (num_objs),
    .scene    (scene),
    .err_cnt  (chk_errs),
    .pix_cnt  (pix_cnt)
  );

  // Scene buffer and pixel sink, both answering on the falling edge
  initial begin
    obj_ack   = 1'b0;
    pix_ack   = 1'b0;
    obj       = '0;
    obj_dly   = 0;
    pix_dly   = 0;
    fetch_cnt = 0;
    dly_state = SEED;
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        obj_ack = 1'b0;
        pix_ack = 1'b0;
      end else begin
        // Scene fetch, ack after the delay, release once req drops
        if (obj_ack && !obj_req) begin
          obj_ack = 1'b0;
        end else if (obj_req && !obj_ack) begin
          if (obj_dly > 0) begin
            obj_dly = obj_dly - 1;
          end else begin
            obj = '0;
            if (obj_idx < OBJ_IDX_W'(MAX_OBJS)) begin
              obj = scene[obj_idx[$clog2(MAX_OBJS)-1:0]];
            end
            obj_ack   = 1'b1;
            fetch_cnt = fetch_cnt + 1;
            obj_dly   = slow ? int'(take_bits(2, dly_state)) : 0;
          end
        end
        // Pixel sink, same four-phase pattern
        if (pix_ack && !pix_req) begin
          pix_ack = 1'b0;
        end else if (pix_req && !pix_ack) begin
          if (pix_dly > 0) begin
            pix_dly = pix_dly - 1;
          end else begin
            pix_ack = 1'b1;
            pix_dly = slow ? int'(take_bits(3, dly_state)) : 0;
          end
        end
      end
    end
  end

  // Camera within +-64 world units
  task automatic new_camera();
    cam.x = 12'($signed(7'(draw(7))));
    cam.y = 12'($signed(7'(draw(7))));
  endtask

  // Sphere centred somewhere inside the current view
  task automatic new_sphere(input int idx, input int rbits, input logic tie);
    sphere_t s;
    s.cx    = cam.x + 12'(draw(4));
    s.cy    = cam.y + 12'(draw(4) % 12);
    // Narrow depth range forces many ties
    s.cz    = tie ? 12'(100 + draw(2)) : 12'(draw(12));
    s.r     = 8'(2 + draw(rbits));
    s.color = 24'(draw(24));
    scene[idx] = s;
  endtask

  // Poll busy at each falling edge, optionally pulsing start meanwhile
  task automatic wait_busy(input logic level, input int limit, input logic poke,
                           output logic ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < limit; n++) begin
      if (busy === level) begin
        ok = 1'b1;
        break;
      end
      if (poke) begin
        start = (draw(3) == 0);
      end
      @(negedge clk);
    end
    start = 1'b0;
  endtask

  task automatic run_frame(input logic poke);
    int   p0;
    int   f0;
    int   exp_f;
    int   n;
    logic ok;
    if (aborted) begin
      return;
    end
    p0    = pix_cnt;
    f0    = fetch_cnt;
    exp_f = int'(num_objs) * FRAME_W * FRAME_H;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait_busy(1'b1, 4, 1'b0, ok);
    if (!ok) begin
      $display("Busy never rose after start, at %0t", $time);
      tb_errs++;
      aborted = 1'b1;
      return;
    end
    wait_busy(1'b0, 40000, poke, ok);
    if (!ok) begin
      $display("Frame did not finish in time, stopped at %0t", $time);
      tb_errs++;
      aborted = 1'b1;
      return;
    end
    if (pix_cnt - p0 != FRAME_W * FRAME_H) begin
      $display("Error at %0t: frame gave %0d pixels, expected %0d",
               $time, pix_cnt - p0, FRAME_W * FRAME_H);
      tb_errs++;
    end
    if (fetch_cnt - f0 != exp_f) begin
      $display("Error at %0t: frame made %0d fetches, expected %0d",
               $time, fetch_cnt - f0, exp_f);
      tb_errs++;
    end
    // Core must stay quiet once the frame is over
    for (n = 0; n < 10; n++) begin
      @(negedge clk);
    end
    if (busy || pix_req || obj_req || pix_cnt - p0 != FRAME_W * FRAME_H) begin
      $display("Error at %0t: activity after the frame ended", $time);
      tb_errs++;
    end
  endtask

  task automatic end_test(input string name, input int e0);
    tests++;
    if (error_total() != e0 || aborted) begin
      failed_tests++;
      $display("Test %0d %s: failed", tests, name);
    end else begin
      $display("Test %0d %s: ok", tests, name);
    end
  endtask

  initial begin
    int   i;
    int   e0;
    logic tie;
    start        = 1'b0;
    cam          = '0;
    num_objs     = '0;
    slow         = 1'b0;
    aborted      = 1'b0;
    tb_errs      = 0;
    tests        = 0;
    failed_tests = 0;
    lfsr_state   = SEED;
    for (i = 0; i < MAX_OBJS; i++) begin
      scene[i] = '0;
    end
    for (i = 0; i < 40 && rst_n !== 1'b1; i++) begin
      @(negedge clk);
    end
    if (rst_n !== 1'b1) begin
      $display("Reset was never released");
      tb_errs++;
      aborted = 1'b1;
    end

    e0 = error_total();
    if (obj_req !== 1'b0 || pix_req !== 1'b0 || busy !== 1'b0) begin
      $display("Error at %0t: after reset obj_req %b pix_req %b busy %b",
               $time, obj_req, pix_req, busy);
      tb_errs++;
    end
    end_test("reset state", e0);

    // No objects, every pixel background and no fetch at all
    e0 = error_total();
    new_camera();
    num_objs = '0;
    run_frame(1'b0);
    end_test("empty scene", e0);

    e0 = error_total();
    new_camera();
    num_objs = OBJ_IDX_W'(1);
    new_sphere(0, 3, 1'b0);
    run_frame(1'b0);
    end_test("single sphere", e0);

    // Large radii overlap, shared depths test the tie rule
    e0 = error_total();
    new_camera();
    num_objs = OBJ_IDX_W'(MAX_OBJS);
    for (i = 0; i < MAX_OBJS; i++) begin
      new_sphere(i, 5, 1'b1);
    end
    run_frame(1'b0);
    end_test("nearest object", e0);

    // Slow handshakes and stray start pulses during the frame
    e0   = error_total();
    slow = 1'b1;
    new_camera();
    tie = draw(1) != 0;
    for (i = 0; i < MAX_OBJS; i++) begin
      new_sphere(i, 4, tie);
    end
    run_frame(1'b1);
    end_test("back-pressure", e0);

    e0 = error_total();
    for (i = 0; i < 3; i++) begin
      new_camera();
      num_objs = OBJ_IDX_W'(1 + draw(3));
      run_frame(1'b0);
    end
    end_test("repeated frames", e0);

    $display("Tests %0d, failed %0d, pixels %0d, errors %0d",
             tests, failed_tests, pix_cnt, error_total());
    if (error_total() == 0 && !aborted) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
hdl/rt_pkg.sv
hdl/pixel_scan.sv
hdl/sphere_hit.sv
hdl/color_565.sv
hdl/trace_fsm.sv
hdl/rtx_core.sv
dv/tb_clock.sv
dv/rtx_checker.sv
dv/rtx_tb.sv

// File: Makefile
# Verilator flow for the ray-casting pixel engine
TOP       ?= rtx_tb
LINT_TOP  ?= rtx_core
SEED      ?= 72573951
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

# Design on its own, then design and testbench together
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f list.f --top-module $(LINT_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f list.f --top-module $(TOP)

# The log decides pass or fail, the simulator's exit status does not
sim:
	$(VERILATOR) --binary $(VFLAGS) -f list.f --top-module $(TOP) -GSEED=$(SEED) \
	  --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
